/* build.f */
+incdir+include
logic/csiRxPkg.sv
logic/csiWordIf.sv
logic/laneMerge.sv
logic/packetParser.sv
logic/videoFifo.sv
logic/csiRxController.sv
tests/tbCsiRxController.sv

/* Makefile */
VERILATOR := verilator
TOP       := tbCsiRxController
RTL_TOP   := csiRxController
FILELIST  := build.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing

SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/csiRx_defines.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* tests/tbCsiRxController.sv */
`include "csiRx_defines.svh"

module tbCsiRxController;
	timeunit 1ns;
	timeprecision 100ps;

	import csiRxPkg::*;

	localparam int clkPeriod = 100;
	localparam int numPackets = 10;
	localparam int burstCycles = 2 + `CSI_FIFO_DEPTH + 1 + 16;	// Header, payload, footer, gap
	localparam int watchdogNs = numPackets * burstCycles * clkPeriod * 4;
	localparam int settleCycles = 8;		// Merge, write, read and valid with slack
	localparam dataTypeT dtRaw8 = 6'h2A;

	// CSI-2 ECC syndrome column per header bit with D23 first
	localparam logic [23:0][5:0] eccColumn = {
		6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,	// D23..D16
		6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,	// D15..D8
		6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07		// D7..D0
	};

	logic		iMipiDphyRx1_WORD_CLKOUT_HS;
	logic		inSRST;
	byteT		rxDataHsLan0;
	byteT		rxDataHsLan1;
	logic		rxValidHsLan0;
	logic		rxValidHsLan1;
	logic		videoFull = 1'b0;
	wordT		videoPixel;
	logic		videoVd;
	logic		fifoFull;
	dataTypeT	hsDatatype;
	wordCntT	hsWordCnt;
	eccT		hsEcc;
	logic		eccErr;
	logic		frameActive;

	// Reference model state
	wordT			expQ[$];				// Pixels still owed by the DUT
	logic			refFrameActive = 1'b0;
	logic [31:0]	rngState = 32'd77;
	logic [31:0]	stallState = 32'd77;
	logic			randomStall = 1'b0;
	logic			holdFull = 1'b0;
	logic			expectVdIdle = 1'b0;	// videoVd must stay low
	dataTypeT		lastType;
	wordCntT		lastWc;
	eccT			lastEcc;
	logic [23:0]	lastHdr;

	csiRxController UUT
	(
		.iMipiDphyRx1_WORD_CLKOUT_HS	(iMipiDphyRx1_WORD_CLKOUT_HS),
		.inSRST							(inSRST),
		.rxDataHsLan0					(rxDataHsLan0),
		.rxDataHsLan1					(rxDataHsLan1),
		.rxValidHsLan0					(rxValidHsLan0),
		.rxValidHsLan1					(rxValidHsLan1),
		.videoFull						(videoFull),
		.videoPixel						(videoPixel),
		.videoVd						(videoVd),
		.fifoFull						(fifoFull),
		.hsDatatype						(hsDatatype),
		.hsWordCnt						(hsWordCnt),
		.hsEcc							(hsEcc),
		.eccErr							(eccErr),
		.frameActive					(frameActive)
	);

	initial
	begin
		iMipiDphyRx1_WORD_CLKOUT_HS = 1'b0;
		forever #(clkPeriod / 2) iMipiDphyRx1_WORD_CLKOUT_HS = ~iMipiDphyRx1_WORD_CLKOUT_HS;
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// XOR of the syndrome columns of all set header bits
	function automatic logic [5:0] refEcc(input logic [23:0] hdr);
		logic [5:0] syn;
		syn = '0;
		for (int i = 0; i < 24; i++)
			if (hdr[i])
				syn = syn ^ eccColumn[i];
		return syn;
	endfunction

	task automatic failRun(input string why);
		$display("%s at %0t ns", why, $time);
		$display("sim failed");
		$fatal(1, "Stopping on first error");
	endtask

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("sim failed");
			$fatal(1, "Stopping on first error");
		end
	endtask

	task automatic driveWord(input byteT hi, input byteT lo);
		@(posedge iMipiDphyRx1_WORD_CLKOUT_HS);
		rxDataHsLan0  <= lo;					// Lane 0 is the low byte
		rxDataHsLan1  <= hi;
		rxValidHsLan0 <= 1'b1;
		rxValidHsLan1 <= 1'b1;
	endtask

	// --------------------
	// Packet stimulus
	// --------------------
	task automatic sendPacket(input dataTypeT dt, input wordCntT wc, input logic corrupt);
		byteT	di;
		eccT	ecc;
		logic	forward;
		di  = {2'b00, dt};						// Virtual channel 0
		ecc = {2'b00, refEcc({wc[15:8], wc[7:0], di})};
		if (corrupt)
			ecc = ecc ^ 8'h04;					// Single bit flip
		forward = !corrupt && (dt > `CSI_SHORT_DT_MAX) && refFrameActive;
		lastType = dt;
		lastWc   = wc;
		lastEcc  = ecc;
		lastHdr  = {wc[15:8], wc[7:0], di};
		driveWord(wc[7:0], di);
		driveWord(ecc, wc[15:8]);
		if (dt > `CSI_SHORT_DT_MAX)
		begin
			for (int i = 0; i < int'(wc) / 2; i++)
			begin
				rngState = nextRandom(rngState);
				driveWord(rngState[15:8], rngState[7:0]);
				if (forward)
					expQ.push_back({rngState[15:8], rngState[7:0]});
			end
			rngState = nextRandom(rngState);
			driveWord(rngState[23:16], rngState[7:0]);		// Footer is never forwarded
		end
		@(posedge iMipiDphyRx1_WORD_CLKOUT_HS);
		rxValidHsLan0 <= 1'b0;
		rxValidHsLan1 <= 1'b0;
		if (!corrupt && dt == `CSI_DT_FS)
			refFrameActive = 1'b1;
		else if (!corrupt && dt == `CSI_DT_FE)
			refFrameActive = 1'b0;
	endtask

	// Two cycles of merge latency and then the parser register
	task automatic checkHeader();
		logic expErr;
		repeat (2) @(posedge iMipiDphyRx1_WORD_CLKOUT_HS);
		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		expErr = (lastEcc != {2'b00, refEcc(lastHdr)});
		checkValue("hsDatatype", hsDatatype, lastType);
		checkValue("hsWordCnt", hsWordCnt, lastWc);
		checkValue("hsEcc", hsEcc, lastEcc);
		checkValue("eccErr", eccErr, expErr);
		checkValue("frameActive", frameActive, refFrameActive);
	endtask

	task automatic waitDrained(input int limit);
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < limit)
		begin
			@(posedge iMipiDphyRx1_WORD_CLKOUT_HS);
			waited++;
		end
		if (expQ.size() != 0)
			failRun("Expected pixels did not arrive on videoVd");
	endtask

	// Fill the FIFO with videoFull high and then release it
	task automatic pressureTest(input int words);
		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		randomStall = 1'b0;
		holdFull    = 1'b1;
		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		expectVdIdle = 1'b1;
		checkValue("fifoFull before burst", fifoFull, 1'b0);
		sendPacket(dtRaw8, wordCntT'(words * 2), 1'b0);
		checkHeader();
		checkValue("fifoFull", fifoFull, words >= `CSI_FIFO_DEPTH - `CSI_FIFO_ALMOST);
		holdFull     = 1'b0;
		expectVdIdle = 1'b0;
		waitDrained(words * 4 + 20);
		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		checkValue("fifoFull after drain", fifoFull, 1'b0);
		randomStall = 1'b1;
	endtask

	// Sink stalls about one cycle in four
	always @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (holdFull)
			videoFull <= 1'b1;
		else if (randomStall)
		begin
			stallState = nextRandom(stallState);
			videoFull <= stallState[3] & stallState[9];
		end
		else
			videoFull <= 1'b0;
	end

	// --------------------
	// Comparator
	// --------------------
	always @(negedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (inSRST && videoVd)
		begin
			if (expectVdIdle)
				failRun("videoVd rose while videoFull was held high");
			else if (expQ.size() == 0)
				failRun("videoVd rose with no pixel expected");
			else
				checkValue("videoPixel", videoPixel, expQ.pop_front());
		end
	end

	initial
	begin
		#(watchdogNs);
		$display("Timeout, the run did not finish within %0d ns", watchdogNs);
		$display("sim failed");
		$fatal(1, "Watchdog expired");
	end

	// --------------------
	// Test sequence
	// --------------------
	initial
	begin
		inSRST        = 1'b0;
		rxDataHsLan0  = '0;
		rxDataHsLan1  = '0;
		rxValidHsLan0 = 1'b0;
		rxValidHsLan1 = 1'b0;
		repeat (2) @(posedge iMipiDphyRx1_WORD_CLKOUT_HS);
		inSRST <= 1'b1;
		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		checkValue("videoVd after reset", videoVd, 1'b0);
		checkValue("eccErr after reset", eccErr, 1'b0);
		checkValue("frameActive after reset", frameActive, 1'b0);
		checkValue("fifoFull after reset", fifoFull, 1'b0);
		randomStall = 1'b1;

		sendPacket(`CSI_DT_FS, 16'd1, 1'b0);		// Frame 1 starts
		checkHeader();
		sendPacket(dtRaw8, 16'd32, 1'b0);
		checkHeader();
		waitDrained(200);
		sendPacket(dtRaw8, 16'd6, 1'b0);
		checkHeader();
		waitDrained(200);

		sendPacket(dtRaw8, 16'd32, 1'b1);			// Bad ECC gives no pixels
		checkHeader();
		repeat (settleCycles) @(posedge iMipiDphyRx1_WORD_CLKOUT_HS);

		sendPacket(`CSI_DT_FE, 16'd1, 1'b0);
		checkHeader();
		sendPacket(dtRaw8, 16'd20, 1'b0);			// Outside a frame
		checkHeader();
		repeat (settleCycles) @(posedge iMipiDphyRx1_WORD_CLKOUT_HS);

		sendPacket(`CSI_DT_FS, 16'd2, 1'b0);
		checkHeader();
		pressureTest(`CSI_FIFO_DEPTH - `CSI_FIFO_ALMOST - 1);	// Just under the flag
		pressureTest(`CSI_FIFO_DEPTH - 2);
		sendPacket(`CSI_DT_FE, 16'd2, 1'b0);
		checkHeader();
		repeat (settleCycles) @(posedge iMipiDphyRx1_WORD_CLKOUT_HS);

		@(negedge iMipiDphyRx1_WORD_CLKOUT_HS);
		if (expQ.size() != 0)
			failRun("Pixels still expected at end of run");
		else
		begin
			$display("sim passed");
			$finish;
		end
	end
endmodule

/* logic/csiRxController.sv */
`include "csiRx_defines.svh"

module csiRxController
(
	// D-PHY side
	input  logic				iMipiDphyRx1_WORD_CLKOUT_HS,	// HS word clock
	input  logic				inSRST,
	input  csiRxPkg::byteT		rxDataHsLan0,
	input  csiRxPkg::byteT		rxDataHsLan1,
	input  logic				rxValidHsLan0,
	input  logic				rxValidHsLan1,
	// Video side
	input  logic				videoFull,			// Back-pressure from sink
	output csiRxPkg::wordT		videoPixel,
	output logic				videoVd,
	output logic				fifoFull,
	// Header status
	output csiRxPkg::dataTypeT	hsDatatype,
	output csiRxPkg::wordCntT	hsWordCnt,
	output csiRxPkg::eccT		hsEcc,
	output logic				eccErr,
	output logic				frameActive
);
	import csiRxPkg::*;

	wordT	fifoWrData;
	logic	fifoWrEn;
	logic	fifoRdEn;
	logic	fifoEmpty;

	csiWordIf mergedWord ();

	// --------------------
	// Lane merge and parse
	// --------------------
	laneMerge uLaneMerge
	(
		.iMipiDphyRx1_WORD_CLKOUT_HS	(iMipiDphyRx1_WORD_CLKOUT_HS),
		.inSRST							(inSRST),
		.rxDataHsLan0					(rxDataHsLan0),
		.rxDataHsLan1					(rxDataHsLan1),
		.rxValidHsLan0					(rxValidHsLan0),
		.rxValidHsLan1					(rxValidHsLan1),
		.wordOut						(mergedWord.source)
	);

	packetParser uPacketParser
	(
		.iMipiDphyRx1_WORD_CLKOUT_HS	(iMipiDphyRx1_WORD_CLKOUT_HS),
		.inSRST							(inSRST),
		.wordIn							(mergedWord.sink),
		.hsDatatype						(hsDatatype),
		.hsWordCnt						(hsWordCnt),
		.hsEcc							(hsEcc),
		.eccErr							(eccErr),
		.frameActive					(frameActive),
		.wrData							(fifoWrData),
		.wrEn							(fifoWrEn)
	);

	// --------------------
	// Video FIFO
	// --------------------
	assign fifoRdEn = ~videoFull & ~fifoEmpty;		// Drain whenever the sink accepts

	videoFifo #(
		.fifoDepth		(`CSI_FIFO_DEPTH),
		.almostMargin	(`CSI_FIFO_ALMOST)
	) uVideoFifo (
		.iMipiDphyRx1_WORD_CLKOUT_HS	(iMipiDphyRx1_WORD_CLKOUT_HS),
		.inSRST							(inSRST),
		.wrData							(fifoWrData),
		.wrEn							(fifoWrEn),
		.rdEn							(fifoRdEn),
		.rdData							(videoPixel),
		.rdValid						(videoVd),
		.empty							(fifoEmpty),
		.almostFull						(fifoFull)
	);
endmodule

/* logic/videoFifo.sv */
`include "csiRx_defines.svh"

module videoFifo #(
	parameter int fifoDepth		= `CSI_FIFO_DEPTH,
	parameter int almostMargin	= `CSI_FIFO_ALMOST
)(
	input  logic			iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic			inSRST,
	input  csiRxPkg::wordT	wrData,
	input  logic			wrEn,
	input  logic			rdEn,
	output csiRxPkg::wordT	rdData,
	output logic			rdValid,		// One cycle after rdEn
	output logic			empty,
	output logic			almostFull
);
	import csiRxPkg::*;

	localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int cntW = $clog2(fifoDepth + 1);

	wordT				mem [fifoDepth];
	logic [ptrW-1:0]	wrPtr;
	logic [ptrW-1:0]	rdPtr;
	logic [cntW-1:0]	count;			// Fill level
	logic				wrAccept;
	logic				rdAccept;

	assign wrAccept   = wrEn && (count != cntW'(fifoDepth));	// Full drops the write
	assign rdAccept   = rdEn && (count != '0);
	assign empty      = (count == '0);
	assign almostFull = (count >= cntW'(fifoDepth - almostMargin));

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (wrAccept)
			mem[wrPtr] <= wrData;
		if (rdAccept)
			rdData <= mem[rdPtr];		// Registered read port
	end

	// --------------------
	// Pointers and level
	// --------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS, negedge inSRST)
	begin
		if (!inSRST)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			rdValid <= rdAccept;
			// Wrap explicitly, depth need not be a power of two
			if (wrAccept)
				wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (rdAccept)
				rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({wrAccept, rdAccept})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;			// Both or neither
			endcase
		end
	end

	countInRange: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) count <= cntW'(fifoDepth))
		else $error("FIFO count above depth");
endmodule

/* logic/packetParser.sv */
`include "csiRx_defines.svh"

module packetParser
(
	input  logic				iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic				inSRST,
	csiWordIf.sink				wordIn,
	output csiRxPkg::dataTypeT	hsDatatype,
	output csiRxPkg::wordCntT	hsWordCnt,
	output csiRxPkg::eccT		hsEcc,
	output logic				eccErr,			// Result of the last header
	output logic				frameActive,
	output csiRxPkg::wordT		wrData,
	output logic				wrEn
);
	import csiRxPkg::*;

	parseStateT		state;
	byteT			diReg;			// Data identifier, VC bits included
	byteT			wcLow;
	wordCntT		remain;			// Payload words still to forward
	logic [23:0]	hdrBits;
	logic [5:0]		eccRef;
	logic			eccBad;
	dataTypeT		hdrType;
	wordCntT		hdrWordCnt;
	logic			isShort;

	// --------------------
	// Header decode
	// --------------------
	// Valid while the second header word is on wordIn
	assign hdrBits    = {wordIn.word[7:0], wcLow, diReg};
	assign eccRef     = eccCalc(hdrBits);
	assign hdrType    = diReg[5:0];					// VC bits ignored
	assign hdrWordCnt = {wordIn.word[7:0], wcLow};
	assign isShort    = (hdrType <= `CSI_SHORT_DT_MAX);

	// Reserved ECC bits count as an error too
	assign eccBad = (wordIn.word[15:14] != 2'b00) || (wordIn.word[13:8] != eccRef);

	// First header word, DI and WC LSB
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (wordIn.valid && wordIn.first)
		begin
			diReg <= wordIn.word[7:0];
			wcLow <= wordIn.word[15:8];
		end
	end

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		wrData <= wordIn.word;		// Qualified by wrEn
	end

	// --------------------
	// Parser FSM
	// --------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS, negedge inSRST)
	begin
		if (!inSRST)
		begin
			state       <= stIdle;
			remain      <= '0;
			hsDatatype  <= '0;
			hsWordCnt   <= '0;
			hsEcc       <= '0;
			eccErr      <= 1'b0;
			frameActive <= 1'b0;
			wrEn        <= 1'b0;
		end
		else
		begin
			wrEn <= 1'b0;
			if (wordIn.valid)
			begin
				if (wordIn.first)		// New burst restarts header parsing
					state <= wordIn.last ? stIdle : stHdr2;
				else
				begin
					case (state)
						stHdr2:
						begin
							hsDatatype <= hdrType;
							hsWordCnt  <= hdrWordCnt;
							hsEcc      <= wordIn.word[15:8];
							eccErr     <= eccBad;
							// FS / FE only with a clean header
							if (!eccBad && isShort)
							begin
								if (hdrType == `CSI_DT_FS)
									frameActive <= 1'b1;
								else if (hdrType == `CSI_DT_FE)
									frameActive <= 1'b0;
							end
							if (wordIn.last)
								state <= stIdle;
							else if (!eccBad && !isShort && frameActive
								&& (hdrWordCnt[15:1] != '0))
							begin
								state  <= stPayload;
								remain <= {1'b0, hdrWordCnt[15:1]};	// Two bytes per word
							end
							else
								state <= stDrop;
						end
						stPayload:
						begin
							wrEn   <= 1'b1;
							remain <= remain - 1'b1;
							if (wordIn.last)
								state <= stIdle;		// Short burst
							else if (remain == wordCntT'(1))
								state <= stDrop;		// Footer follows
						end
						stDrop:
						begin
							if (wordIn.last)
								state <= stIdle;
						end
						default:
						begin
							state <= stIdle;			// Stray word, wait for first
						end
					endcase
				end
			end
		end
	end

	// Write strobe is one cycle behind the payload state
	wrEnInPayload: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) wrEn |-> $past(state) == stPayload)
		else $error("wrEn outside payload");

	// Idle gap from laneMerge keeps writes clear of the next header
	wrEnNotFirst: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) !(wrEn && wordIn.valid && wordIn.first))
		else $error("wrEn on first word");
endmodule

/* logic/laneMerge.sv */
module laneMerge
(
	input  logic			iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic			inSRST,
	input  csiRxPkg::byteT	rxDataHsLan0,		// Lower byte
	input  csiRxPkg::byteT	rxDataHsLan1,		// Upper byte
	input  logic			rxValidHsLan0,
	input  logic			rxValidHsLan1,
	csiWordIf.source		wordOut
);
	import csiRxPkg::*;

	logic	laneValid;		// Both lanes carry a byte
	logic	holdValid;
	logic	holdFirst;
	wordT	holdWord;

	assign laneValid = rxValidHsLan0 & rxValidHsLan1;

	// --------------------
	// Hold stage
	// --------------------
	// One cycle of look-ahead so the last word can be seen
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS, negedge inSRST)
	begin
		if (!inSRST)
		begin
			holdValid <= 1'b0;
			holdFirst <= 1'b0;
		end
		else
		begin
			holdValid <= laneValid;
			holdFirst <= laneValid & ~holdValid;	// Idle before this byte pair
		end
	end

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (laneValid)
			holdWord <= {rxDataHsLan1, rxDataHsLan0};
	end

	// --------------------
	// Output stage
	// --------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS, negedge inSRST)
	begin
		if (!inSRST)
		begin
			wordOut.valid <= 1'b0;
			wordOut.first <= 1'b0;
			wordOut.last  <= 1'b0;
		end
		else
		begin
			wordOut.valid <= holdValid;
			wordOut.first <= holdValid & holdFirst;
			wordOut.last  <= holdValid & ~laneValid;	// Valids fall next
		end
	end

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		wordOut.word <= holdWord;
	end

	// Two-lane link, both lanes must start and stop together
	laneValidMatch: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) rxValidHsLan0 == rxValidHsLan1)
		else $error("Lane valids differ");
endmodule

/* logic/csiWordIf.sv */
// Merged lane words from laneMerge to packetParser
interface csiWordIf;
	import csiRxPkg::*;

	wordT	word;		// {lane1, lane0}
	logic	valid;
	logic	first;		// Start of burst
	logic	last;		// Final word before valids fall

	// No ready, the PHY cannot stall
	modport source
	(
		output word,
		output valid,
		output first,
		output last
	);

	modport sink
	(
		input word,
		input valid,
		input first,
		input last
	);
endinterface

/* logic/csiRxPkg.sv */
package csiRxPkg;

	typedef logic [7:0]		byteT;		// One lane byte
	typedef logic [15:0]	wordT;		// Lane 1 in the upper byte
	typedef logic [5:0]		dataTypeT;
	typedef logic [15:0]	wordCntT;	// Payload length in bytes
	typedef logic [7:0]		eccT;		// Bits 7:6 always zero on the wire

	// Parser FSM
	typedef enum logic [1:0]
	{
		stIdle,			// Waiting for first word of a burst
		stHdr2,			// Second header word expected
		stPayload,		// Forwarding payload words
		stDrop			// Discard until end of burst
	} parseStateT;

	// --------------------
	// Header ECC
	// --------------------
	// Hamming code over DI, WC LSB and WC MSB, one parity mask per bit
	function automatic logic [5:0] eccCalc(input logic [23:0] hdr);
		logic [5:0] ecc;
		ecc[0] = ^(hdr & 24'hF12CB7);
		ecc[1] = ^(hdr & 24'hF2555B);
		ecc[2] = ^(hdr & 24'h749A6D);
		ecc[3] = ^(hdr & 24'hB8E38E);
		ecc[4] = ^(hdr & 24'hDF03F0);
		ecc[5] = ^(hdr & 24'hEFFC00);
		return ecc;
	endfunction

endpackage

/* include/csiRx_defines.svh */
`ifndef CSIRX_DEFINES_SVH
`define CSIRX_DEFINES_SVH

// --------------------
// Video FIFO sizing
// --------------------
`define CSI_FIFO_DEPTH		64		// Words of 16 bits
`define CSI_FIFO_ALMOST		4		// fifoFull margin below depth

// --------------------
// CSI-2 data types
// --------------------
// Types 0x00..0x0F are short packets, header only
`define CSI_SHORT_DT_MAX	6'h0F

`define CSI_DT_FS			6'h00	// Frame start
`define CSI_DT_FE			6'h01	// Frame end

// Long packet types start above the short range

`endif
